// File: test/heapTrace.txt
# name action array index dataIn expDataOut expError (all hex)
# action 0 Alloc 1 Free 2 Write 3 Read 4 Size 5 Push 6 Pop 7 Add 8 Subtract
neverLive      3 2 0 000 000 1
alloc0         0 0 0 000 000 0
alloc1         0 0 0 000 001 0
alloc2         0 0 0 000 002 0
alloc3         0 0 0 000 003 0
allocNoMem     0 0 0 000 003 5
free1          1 1 0 000 003 0
free3          1 3 0 000 003 0
reuse3         0 0 0 000 003 0
reuse1         0 0 0 000 001 0
writeIdx5      2 0 5 abc abc 0
sizeAfterWrite 4 0 0 000 006 0
readPastSize   3 0 6 000 006 2
readIdx5       3 0 5 000 abc 0
push1          5 1 0 101 abc 0
push2          5 1 0 102 abc 0
push3          5 1 0 103 abc 0
push4          5 1 0 104 abc 0
push5          5 1 0 105 abc 0
push6          5 1 0 106 abc 0
push7          5 1 0 107 abc 0
push8          5 1 0 108 abc 0
pushFull       5 1 0 109 abc 3
pop8           6 1 0 000 108 0
pop7           6 1 0 000 107 0
pop6           6 1 0 000 106 0
pop5           6 1 0 000 105 0
pop4           6 1 0 000 104 0
pop3           6 1 0 000 103 0
pop2           6 1 0 000 102 0
pop1           6 1 0 000 101 0
popEmpty       6 1 0 000 101 4
writeArith     2 2 0 ff0 ff0 0
addWrap        7 2 0 020 010 0
subWrap        8 2 0 015 ffb 0
readDiff       3 2 0 000 ffb 0
free2          1 2 0 000 ffb 0
readFreed      3 2 0 000 ffb 1
freeTwice      1 2 0 000 ffb 1
realloc2       0 0 0 000 002 0
sizeRealloc    4 2 0 000 000 0

// File: compile.f
design/heapPkg.sv
design/heapBusIf.sv
design/heapAllocator.sv
design/heapArrayStore.sv
design/heapUnit.sv
test/heapUnit_asserts.sv
test/heapUnitTb.sv

// File: Makefile
# Verilator build and run for the array heap
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = heapUnitTb
FILELIST  = compile.f
OBJDIR    = obj_dir
LOG       = sim.log

SOURCES = $(shell cat $(FILELIST))
SIMBIN  = $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(SIMBIN)

$(SIMBIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIMBIN)
	./$(SIMBIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then \
	  echo "Simulation FAILED"; exit 1; \
	elif ! grep -q "All tests passed!" $(LOG); then \
	  echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: test/heapUnitTb.sv
//----------------------------------------------------------------------
// Testbench for the array heap. Replays the request trace one line at
// a time and checks dataOut and error against the expected columns.
//----------------------------------------------------------------------
`timescale 1ns/10ps

module heapUnitTb import heapPkg::*; ();

  typedef struct packed {
    logic [8*24-1:0] name;                           // Test name as text
    heapAction_t     action;
    arrayNum_t       array;
    elemIndex_t      index;
    heapData_t       dataIn;
    heapData_t       expData;
    heapErr_t        expErr;
  } traceLine_t;

  logic        clock;
  logic        resetN;
  logic        valid;
  heapAction_t action;
  arrayNum_t   array;
  elemIndex_t  index;
  heapData_t   dataIn;
  heapData_t   dataOut;
  heapErr_t    error;
  logic        done;

  traceLine_t  trace [$];                            // All requests, in file order
  logic        traceLoaded;

  heapUnit UUT (.*);

  always #20 clock = ~clock;                         // 40 ns period

  //--------------------------------------------------------------------
  // Helpers
  //--------------------------------------------------------------------
  task automatic loadTrace();
    int              fd;
    int              count;
    string           text;
    logic [8*24-1:0] name;
    logic [3:0]      act;
    arrayNum_t       arr;
    elemIndex_t      idx;
    heapData_t       din;
    heapData_t       expData;
    logic [2:0]      expErr;
    traceLine_t      entry;
    fd = $fopen("test/heapTrace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file test/heapTrace.txt");
      $display("Test failures found");
      $fatal(1, "Missing stimulus");
    end
    while (!$feof(fd)) begin
      text = "";
      void'($fgets(text, fd));
      if (text.len() > 1 && text[0] != "#") begin  // Skip blank and comment lines
        count = $sscanf(text, "%s %h %h %h %h %h %h",
                        name, act, arr, idx, din, expData, expErr);
        if (count == 7) begin
          entry.name    = name;
          entry.action  = heapAction_t'(act);
          entry.array   = arr;
          entry.index   = idx;
          entry.dataIn  = din;
          entry.expData = expData;
          entry.expErr  = heapErr_t'(expErr);
          trace.push_back(entry);
        end else begin
          $display("A trace line could not be read: %0s", text);
          $display("Test failures found");
          $fatal(1, "Bad stimulus");
        end
      end
    end
    $fclose(fd);
    if (trace.size() == 0) begin
      $display("The trace file holds no requests");
      $display("Test failures found");
      $fatal(1, "Empty stimulus");
    end
  endtask

  task automatic checkValue(input logic [8*24-1:0] testName, input string what,
                            input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %0s: %0s expected %h, actual %h",
               testName, what, expected, actual);
      $display("Test failures found");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // Entered and left 2 ns after a rising edge
  task automatic runRequest(input traceLine_t entry);
    int waited;
    valid  = 1'b1;
    action = entry.action;
    array  = entry.array;
    index  = entry.index;
    dataIn = entry.dataIn;
    @(posedge clock);                                // DUT samples here
    #2;
    valid  = 1'b0;
    waited = 0;
    while (!done && waited < 4) begin
      @(posedge clock);
      #2;
      waited++;
    end
    if (!done) begin
      $display("No done pulse arrived for request %0s", entry.name);
      $display("Test failures found");
      $fatal(1, "Missing response");
    end
    checkValue(entry.name, "dataOut", 32'(entry.expData), 32'(dataOut));
    checkValue(entry.name, "error", 32'(entry.expErr), 32'(error));
  endtask

  //--------------------------------------------------------------------
  // Main sequence and watchdog
  //--------------------------------------------------------------------
  initial begin
    clock       = 1'b0;
    resetN      = 1'b0;
    valid       = 1'b0;
    action      = Alloc;
    array       = '0;
    index       = '0;
    dataIn      = '0;
    traceLoaded = 1'b0;
    loadTrace();
    traceLoaded = 1'b1;
    repeat (10) @(posedge clock);                    // Reset for 10 cycles
    #2;
    resetN = 1'b1;
    foreach (trace[i]) begin
      runRequest(trace[i]);
    end
    @(posedge clock);
    $display("All tests passed!");
    $finish;
  end

  initial begin
    wait (traceLoaded);
    #((trace.size() + 20) * 40);                     // One cycle per line plus margin
    $display("Timeout: the trace did not finish in the time allowed");
    $display("Test failures found");
    $fatal(1, "Watchdog expired");
  end

endmodule

// File: test/heapUnit_asserts.sv
//----------------------------------------------------------------------
// Timing checks on the heap response strobe. Bound into heapUnit
// below, so every instance of the top is checked.
//----------------------------------------------------------------------
`timescale 1ns/10ps

module heapUnitAsserts import heapPkg::*; (
  input logic     clock,
  input logic     resetN,
  input logic     valid,
  input logic     done,
  input heapErr_t error
);

  // Response exactly one cycle after the request
  assert property (@(posedge clock) disable iff (!resetN) valid |=> done)
    else $error("done did not follow a request by one cycle");

  assert property (@(posedge clock) disable iff (!resetN) done |-> $past(valid))
    else $error("done rose without a request");

  assert property (@(posedge clock) !resetN |-> error == errNone)
    else $error("error code not cleared while in reset");

endmodule

bind heapUnit heapUnitAsserts timingChecks (
  .clock  (clock),
  .resetN (resetN),
  .valid  (valid),
  .done   (done),
  .error  (error)
);

// File: design/heapUnit.sv
//----------------------------------------------------------------------
// Top of the array heap. Plain request ports feed the internal bus;
// the allocator and the array store sit side by side on it.
//----------------------------------------------------------------------
`timescale 1ns/10ps

module heapUnit import heapPkg::*; (
  input  logic        clock,
  input  logic        resetN,                        // Asynchronous, active low
  input  logic        valid,                         // One request per high cycle
  input  heapAction_t action,
  input  arrayNum_t   array,
  input  elemIndex_t  index,
  input  heapData_t   dataIn,
  output heapData_t   dataOut,
  output heapErr_t    error,
  output logic        done                           // Response strobe
);

  heapBusIf bus ();

  // Source side of the bus
  assign bus.valid  = valid;
  assign bus.action = action;
  assign bus.array  = array;
  assign bus.index  = index;
  assign bus.dataIn = dataIn;

  heapAllocator allocator (
    .clock  (clock),
    .resetN (resetN),
    .bus    (bus.allocator)
  );

  heapArrayStore store (
    .clock   (clock),
    .resetN  (resetN),
    .bus     (bus.store),
    .dataOut (dataOut),
    .error   (error),
    .done    (done)
  );

endmodule

// File: design/heapArrayStore.sv
//----------------------------------------------------------------------
// Element memory and array sizes of the heap. Decodes each request,
// picks the error code and registers the response, which appears with
// done one cycle after the request strobe.
//----------------------------------------------------------------------
`timescale 1ns/10ps

module heapArrayStore import heapPkg::*; (
  input  logic     clock,
  input  logic     resetN,
  heapBusIf.store  bus,
  output heapData_t dataOut,
  output heapErr_t error,
  output logic     done
);

  heapData_t elemMem    [heapArrays][arrayLength];   // Fixed blocks, one per array
  elemSize_t arraySizes [heapArrays];                // Current size of each array

  elemSize_t  curSize;                               // Size of requested array
  heapData_t  curElem;                               // Element at index
  elemIndex_t topIndex;                              // Last used slot
  logic       inBounds;
  heapData_t  sum;
  heapData_t  diff;

  heapErr_t   errNext;
  logic       outLoad;
  heapData_t  outNext;
  logic       sizeLoad;
  arrayNum_t  sizeArray;
  elemSize_t  sizeNext;
  logic       memLoad;
  elemIndex_t memIndex;
  heapData_t  memData;
  logic       accept;                                // Request with no error

  assign curSize  = arraySizes[bus.array];
  assign curElem  = elemMem[bus.array][bus.index];
  assign topIndex = elemIndex_t'(curSize - 1'b1);
  assign inBounds = (elemSize_t'(bus.index) < curSize);
  assign sum      = curElem + bus.dataIn;            // Wraps at 12 bits
  assign diff     = curElem - bus.dataIn;

  //--------------------------------------------------------------------
  // Action decode
  //--------------------------------------------------------------------
  always_comb begin
    errNext   = errNone;
    outLoad   = 1'b0;
    outNext   = curElem;
    sizeLoad  = 1'b0;
    sizeArray = bus.array;
    sizeNext  = curSize;
    memLoad   = 1'b0;
    memIndex  = bus.index;
    memData   = bus.dataIn;

    if (bus.action != Alloc && !bus.arrayLive) begin
      errNext = errNotAllocated;                     // Checked before anything else
    end

    case (bus.action)
      Alloc: begin
        if (!bus.grantValid) errNext = errOutOfMemory;
        outLoad   = 1'b1;
        outNext   = heapData_t'(bus.grantArray);
        sizeLoad  = 1'b1;
        sizeArray = bus.grantArray;                  // New array starts empty
        sizeNext  = '0;
      end
      Write: begin
        memLoad = 1'b1;
        outLoad = 1'b1;
        outNext = bus.dataIn;
        if (!inBounds) begin
          sizeLoad = 1'b1;                           // Grow to cover index
          sizeNext = elemSize_t'(bus.index) + 1'b1;
        end
      end
      Read: begin
        if (bus.arrayLive && !inBounds) errNext = errOutOfBounds;
        outLoad = 1'b1;
      end
      Size: begin
        outLoad = 1'b1;
        outNext = heapData_t'(curSize);
      end
      Push: begin
        if (bus.arrayLive && curSize == elemSize_t'(arrayLength)) errNext = errFull;
        memLoad  = 1'b1;
        memIndex = elemIndex_t'(curSize);
        sizeLoad = 1'b1;
        sizeNext = curSize + 1'b1;
      end
      Pop: begin
        if (bus.arrayLive && curSize == '0) errNext = errEmpty;
        outLoad  = 1'b1;
        outNext  = elemMem[bus.array][topIndex];
        sizeLoad = 1'b1;
        sizeNext = curSize - 1'b1;
      end
      Add, Subtract: begin
        if (bus.arrayLive && !inBounds) errNext = errOutOfBounds;
        memLoad = 1'b1;
        memData = (bus.action == Add) ? sum : diff;
        outLoad = 1'b1;
        outNext = memData;
      end
      default: begin
        outLoad = 1'b0;                              // Free and unknown codes
      end
    endcase
  end

  assign accept = bus.valid && (errNext == errNone);

  //--------------------------------------------------------------------
  // Response and sizes
  //--------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      done    <= 1'b0;
      error   <= errNone;
      dataOut <= '0;
      for (int a = 0; a < heapArrays; a++) begin
        arraySizes[a] <= '0;
      end
    end else begin
      done <= bus.valid;                             // One pulse per request
      if (bus.valid) error <= errNext;
      if (accept && outLoad) dataOut <= outNext;
      if (accept && sizeLoad) arraySizes[sizeArray] <= sizeNext;
    end
  end

  always_ff @(posedge clock) begin
    if (accept && memLoad) begin
      elemMem[bus.array][memIndex] <= memData;
    end
  end

endmodule

// File: design/heapAllocator.sv
//----------------------------------------------------------------------
// Allocation bookkeeping for the heap: live flags, a LIFO of freed
// array numbers and a counter of never-used arrays. Status outputs are
// combinational; state moves on a successful Alloc or Free.
//----------------------------------------------------------------------
`timescale 1ns/10ps

module heapAllocator import heapPkg::*; (
  input logic      clock,
  input logic      resetN,
  heapBusIf.allocator bus
);

  logic [heapArrays-1:0] liveFlags;                  // One bit per array
  arrayNum_t             freeStack [heapArrays];     // Freed arrays, newest on top
  stackDepth_t           freeDepth;                  // Entries on the free stack
  stackDepth_t           nextUnused;                 // Lowest never-used array

  arrayNum_t topSlot;                                // Slot of the newest entry
  logic      stackEmpty;
  logic      allocOk;
  logic      freeOk;

  //--------------------------------------------------------------------
  // Status toward the store
  //--------------------------------------------------------------------
  assign topSlot    = arrayNum_t'(freeDepth - 1'b1);
  assign stackEmpty = (freeDepth == '0);

  assign bus.arrayLive  = liveFlags[bus.array];
  assign bus.grantValid = !stackEmpty || (nextUnused < stackDepth_t'(heapArrays));
  assign bus.grantArray = stackEmpty ? arrayNum_t'(nextUnused) // Fresh array
                                     : freeStack[topSlot];     // Reuse latest freed

  assign allocOk = bus.valid && (bus.action == Alloc) && bus.grantValid;
  assign freeOk  = bus.valid && (bus.action == Free) && bus.arrayLive;

  //--------------------------------------------------------------------
  // Bookkeeping state
  //--------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      liveFlags  <= '0;                              // Everything free
      freeDepth  <= '0;
      nextUnused <= '0;
    end else begin
      if (allocOk) begin
        liveFlags[bus.grantArray] <= 1'b1;
        if (stackEmpty) begin
          nextUnused <= nextUnused + 1'b1;           // Take a fresh one
        end else begin
          freeDepth <= freeDepth - 1'b1;             // Pop the stack
        end
      end
      if (freeOk) begin
        liveFlags[bus.array] <= 1'b0;
        freeDepth            <= freeDepth + 1'b1;
      end
    end
  end

  // Stack entries only matter below freeDepth
  always_ff @(posedge clock) begin
    if (freeOk) begin
      freeStack[arrayNum_t'(freeDepth)] <= bus.array; // Never overflows, depth < 4 here
    end
  end

endmodule

// File: design/heapBusIf.sv
//----------------------------------------------------------------------
// Request and allocation status shared by the heap blocks. The top
// drives the request; the allocator answers with liveness and grant.
//----------------------------------------------------------------------
`timescale 1ns/10ps

interface heapBusIf import heapPkg::*; ();

  logic        valid;                                // Request strobe
  heapAction_t action;
  arrayNum_t   array;
  elemIndex_t  index;
  heapData_t   dataIn;

  logic        arrayLive;                            // Requested array is allocated
  logic        grantValid;                           // An array is available
  arrayNum_t   grantArray;                           // Array an Alloc would get

  modport source    (output valid, action, array, index, dataIn);

  modport allocator (input  valid, action, array, index, dataIn,
                     output arrayLive, grantValid, grantArray);

  modport store     (input  valid, action, array, index, dataIn,
                     input  arrayLive, grantValid, grantArray);

  modport monitor   (input  valid, action, array, index, dataIn,
                     input  arrayLive, grantValid, grantArray);

endinterface

// File: design/heapPkg.sv
//----------------------------------------------------------------------
// Shared sizes, types and codes for the array heap. Import with
// heapPkg::* in the header of any block that talks to the heap.
//----------------------------------------------------------------------
package heapPkg;

  //--------------------------------------------------------------------
  // Sizes
  //--------------------------------------------------------------------
  localparam int heapArrays  = 4;                    // Arrays in the heap
  localparam int arrayLength = 8;                    // Elements per array
  localparam int dataBits    = 12;                   // Element width
  localparam int depthBits   = $clog2(heapArrays + 1); // Free stack depth 0..4

  //--------------------------------------------------------------------
  // Types
  //--------------------------------------------------------------------
  typedef logic [$clog2(heapArrays)-1:0]      arrayNum_t;   // Array number
  typedef logic [$clog2(arrayLength)-1:0]     elemIndex_t;  // Element index
  typedef logic [$clog2(arrayLength+1)-1:0]   elemSize_t;   // Size 0..8
  typedef logic [dataBits-1:0]                heapData_t;   // Element value
  typedef logic [depthBits-1:0]               stackDepth_t; // Free stack depth

  // Request codes
  typedef enum logic [3:0] {
    Alloc    = 4'd0,                                 // Claim an array
    Free     = 4'd1,                                 // Give an array back
    Write    = 4'd2,                                 // Store at index
    Read     = 4'd3,                                 // Load from index
    Size     = 4'd4,                                 // Current size
    Push     = 4'd5,                                 // Append at the end
    Pop      = 4'd6,                                 // Remove from the end
    Add      = 4'd7,                                 // Element plus dataIn
    Subtract = 4'd8                                  // Element minus dataIn
  } heapAction_t;

  // Response status, valid alongside done
  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,                          // Array not live
    errOutOfBounds  = 3'd2,                          // Index at or past size
    errFull         = 3'd3,                          // Push on a full array
    errEmpty        = 3'd4,                          // Pop on an empty array
    errOutOfMemory  = 3'd5                           // No array left to hand out
  } heapErr_t;

endpackage
